/* Bender.yml */
package:
  name: display_pipe

sources:
  - pipe_pkg.sv
  - video_timing_gen.sv
  - display_ctrl.sv
  - word_fifo.sv
  - byte_unpacker.sv
  - pixel_formatter.sv
  - display_pipe_top.sv
  - target: test
    files:
      - display_pipe_properties.sv
      - tb_display_pipe.sv

/* byte_unpacker.sv */
`default_nettype none
`timescale 1ns/1ps

module byte_unpacker (
    input  logic                  vtc_clk,
    input  logic                  arst_n_i,
    input  pipe_pkg::video_sync_t sync_i,
    input  pipe_pkg::mem_word_t   head_i,
    input  pipe_pkg::fifo_level_t level_i,
    output logic                  pop_o,
    output logic                  starve_o,
    output pipe_pkg::video_sync_t sync_o,
    output pipe_pkg::pixel_t      pixel_o
);
    import pipe_pkg::*;

    logic [1:0] byte_cnt_q;
    mem_word_t  word_q;     // word being unpacked
    mem_word_t  word_sel;
    logic       fifo_empty;

    assign fifo_empty = (level_i == '0);
    assign pop_o      = sync_i.de && (byte_cnt_q == 2'd0);
    assign starve_o   = pop_o && fifo_empty;
    // fresh word on byte 0, missing word reads as zero
    assign word_sel   = (byte_cnt_q != 2'd0) ? word_q : (fifo_empty ? '0 : head_i);

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            byte_cnt_q <= 2'd0;
            sync_o     <= '0;
        end else begin
            sync_o     <= sync_i;   // matches the pixel register
            byte_cnt_q <= sync_i.de ? byte_cnt_q + 2'd1 : 2'd0;
        end
    end

    always_ff @(posedge vtc_clk) begin
        if (pop_o) begin
            word_q <= word_sel;
        end
        if (sync_i.de) begin
            case (byte_cnt_q)   // msb first
                2'd0:    pixel_o <= word_sel[31:24];
                2'd1:    pixel_o <= word_sel[23:16];
                2'd2:    pixel_o <= word_sel[15:8];
                default: pixel_o <= word_sel[7:0];
            endcase
        end else begin
            pixel_o <= '0;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
pipe_pkg.sv
video_timing_gen.sv
display_ctrl.sv
word_fifo.sv
byte_unpacker.sv
pixel_formatter.sv
display_pipe_top.sv
display_pipe_properties.sv
tb_display_pipe.sv

/* display_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module display_ctrl (
    input  logic                  vtc_clk,
    input  logic                  arst_n_i,
    input  logic                  flush_i,
    input  pipe_pkg::fifo_level_t fifo_level_i,
    input  logic                  mem_ack_i,
    input  pipe_pkg::mem_word_t   mem_data_i,
    output logic                  mem_req_o,
    output pipe_pkg::word_addr_t  mem_addr_o,
    output logic                  push_o,
    output pipe_pkg::mem_word_t   push_data_o,
    output logic                  fifo_clear_o,
    input  logic                  starve_i,
    output logic                  underrun_o
);
    import pipe_pkg::*;

    fetch_state_t state_q;
    word_addr_t   word_addr_q;
    logic         fetch_done_q;
    logic         discard_q;       // pending word belongs to the previous frame
    fifo_level_t  committed_level;
    logic         room;
    logic         fetch_go;
    logic         capture;
    logic         raise;

    // a push still on its way counts as occupied
    assign committed_level = fifo_level_i + fifo_level_t'(push_o);
    assign room            = committed_level < fifo_level_t'(fifo_depth);
    assign fetch_go        = (flush_i || !fetch_done_q) && room;
    assign capture         = (state_q == FETCH_REQ) && mem_ack_i;
    assign raise           = fetch_go && ((state_q == FETCH_IDLE) ||
                             ((state_q == FETCH_RELEASE) && !mem_ack_i));

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= FETCH_IDLE;
            mem_req_o    <= 1'b0;
            mem_addr_o   <= '0;
            word_addr_q  <= '0;
            fetch_done_q <= 1'b0;
            discard_q    <= 1'b0;
            push_o       <= 1'b0;
            fifo_clear_o <= 1'b0;
            underrun_o   <= 1'b0;
        end else begin
            push_o       <= capture && !discard_q && !flush_i;
            fifo_clear_o <= flush_i;

            if (raise) begin
                mem_req_o  <= 1'b1;
                mem_addr_o <= flush_i ? '0 : word_addr_q;   // held until ack
                state_q    <= FETCH_REQ;
            end else if (capture) begin
                mem_req_o <= 1'b0;
                state_q   <= FETCH_RELEASE;
            end else if ((state_q == FETCH_RELEASE) && !mem_ack_i) begin
                state_q <= FETCH_IDLE;
            end

            if (flush_i) begin
                word_addr_q  <= '0;
                fetch_done_q <= 1'b0;
            end else if (capture && !discard_q) begin
                word_addr_q <= word_addr_q + word_addr_t'(1);
                if (word_addr_q == word_addr_t'(frame_words - 1)) begin
                    fetch_done_q <= 1'b1;
                end
            end

            // a request in flight across the flush must finish, its data is dropped
            if (flush_i) begin
                discard_q <= (state_q == FETCH_REQ) && !mem_ack_i;
            end else if (capture) begin
                discard_q <= 1'b0;
            end

            if (flush_i) begin
                underrun_o <= 1'b0;
            end else if (starve_i) begin
                underrun_o <= 1'b1;   // sticky until next frame
            end
        end
    end

    always_ff @(posedge vtc_clk) begin
        if (capture) begin
            push_data_o <= mem_data_i;
        end
    end

endmodule

`default_nettype wire

/* display_pipe_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module display_pipe_properties (
    input logic                  vtc_clk,
    input logic                  arst_n_i,
    input logic                  mem_req_i,
    input logic                  mem_ack_i,
    input pipe_pkg::word_addr_t  mem_addr_i,
    input logic                  push_i,
    input pipe_pkg::fifo_level_t fifo_level_i
);
    import pipe_pkg::*;

    int assert_fails = 0;   // count of failed checks

    req_held_until_ack: assert property (
        @(posedge vtc_clk) disable iff (!arst_n_i)
        mem_req_i && !mem_ack_i |=> mem_req_i
    ) else begin
        assert_fails++;
        $error("memory request dropped before ack");
    end

    addr_stable_in_req: assert property (
        @(posedge vtc_clk) disable iff (!arst_n_i)
        mem_req_i && $past(mem_req_i) |-> $stable(mem_addr_i)
    ) else begin
        assert_fails++;
        $error("memory address changed while req was high");
    end

    no_req_during_ack: assert property (
        @(posedge vtc_clk) disable iff (!arst_n_i)
        $rose(mem_req_i) |-> !$past(mem_ack_i)
    ) else begin
        assert_fails++;
        $error("memory request raised while ack was high");
    end

    no_push_when_full: assert property (
        @(posedge vtc_clk) disable iff (!arst_n_i)
        push_i |-> fifo_level_i != fifo_level_t'(fifo_depth)
    ) else begin
        assert_fails++;
        $error("word pushed into a full FIFO");
    end

endmodule

bind display_ctrl display_pipe_properties u_props (
    .vtc_clk      (vtc_clk),
    .arst_n_i     (arst_n_i),
    .mem_req_i    (mem_req_o),
    .mem_ack_i    (mem_ack_i),
    .mem_addr_i   (mem_addr_o),
    .push_i       (push_o),
    .fifo_level_i (fifo_level_i)
);

`default_nettype wire

/* display_pipe_top.sv */
`default_nettype none
`timescale 1ns/1ps

module display_pipe_top (
    input  logic                  vtc_clk,
    input  logic                  arst_n_i,
    output logic                  mem_req_o,
    output pipe_pkg::word_addr_t  mem_addr_o,
    input  logic                  mem_ack_i,
    input  pipe_pkg::mem_word_t   mem_data_i,
    input  pipe_pkg::out_mode_t   mode_i,
    input  pipe_pkg::pixel_t      threshold_i,
    output pipe_pkg::video_sync_t video_o,
    output pipe_pkg::rgb_t        pixel_o,
    output logic                  underrun_o
);
    import pipe_pkg::*;

    video_sync_t raw_sync;      // timing generator output
    video_sync_t unpack_sync;   // one cycle later
    logic        flush;
    fifo_level_t fifo_level;
    logic        push;
    mem_word_t   push_data;
    logic        fifo_clear;
    mem_word_t   fifo_head;
    logic        pop;
    logic        starve;
    pixel_t      raw_pixel;

    video_timing_gen u_timing (
        .vtc_clk  (vtc_clk),
        .arst_n_i (arst_n_i),
        .sync_o   (raw_sync),
        .flush_o  (flush)
    );

    display_ctrl u_ctrl (
        .vtc_clk      (vtc_clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush),
        .fifo_level_i (fifo_level),
        .mem_ack_i    (mem_ack_i),
        .mem_data_i   (mem_data_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .push_o       (push),
        .push_data_o  (push_data),
        .fifo_clear_o (fifo_clear),
        .starve_i     (starve),
        .underrun_o   (underrun_o)
    );

    word_fifo u_fifo (
        .vtc_clk     (vtc_clk),
        .arst_n_i    (arst_n_i),
        .clear_i     (fifo_clear),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (fifo_head),
        .level_o     (fifo_level)
    );

    byte_unpacker u_unpack (
        .vtc_clk  (vtc_clk),
        .arst_n_i (arst_n_i),
        .sync_i   (raw_sync),
        .head_i   (fifo_head),
        .level_i  (fifo_level),
        .pop_o    (pop),
        .starve_o (starve),
        .sync_o   (unpack_sync),
        .pixel_o  (raw_pixel)
    );

    pixel_formatter u_format (
        .vtc_clk     (vtc_clk),
        .arst_n_i    (arst_n_i),
        .sync_i      (unpack_sync),
        .pixel_i     (raw_pixel),
        .mode_i      (mode_i),
        .threshold_i (threshold_i),
        .sync_o      (video_o),
        .rgb_o       (pixel_o)
    );

endmodule

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // horizontal raster in pixels
    localparam int h_active = 16;
    localparam int h_fp     = 2;
    localparam int h_sync   = 2;
    localparam int h_bp     = 4;
    localparam int h_total  = h_active + h_fp + h_sync + h_bp;   // 24

    // vertical raster in lines
    localparam int v_active = 4;
    localparam int v_fp     = 1;
    localparam int v_sync   = 1;
    localparam int v_bp     = 2;
    localparam int v_total  = v_active + v_fp + v_sync + v_bp;   // 8

    // four raw pixels per frame-buffer word
    localparam int words_per_line = h_active / 4;
    localparam int frame_words    = words_per_line * v_active;   // 16

    localparam int fifo_depth = 8;

    typedef logic [7:0]  pixel_t;        // raw pixel or one colour channel
    typedef logic [31:0] mem_word_t;     // frame-buffer word, msb byte first
    typedef logic [3:0]  word_addr_t;    // word index within a frame
    typedef logic [3:0]  fifo_level_t;   // 0 .. fifo_depth
    typedef logic [4:0]  hcount_t;
    typedef logic [2:0]  vcount_t;

    typedef struct packed {
        pixel_t red;
        pixel_t green;
        pixel_t blue;
    } rgb_t;

    typedef struct packed {
        logic vs;
        logic hs;
        logic de;
    } video_sync_t;

    typedef enum logic {
        MODE_GREY   = 1'b0,
        MODE_BINARY = 1'b1
    } out_mode_t;

    // four-phase fetch handshake
    typedef enum logic [1:0] {
        FETCH_IDLE    = 2'd0,
        FETCH_REQ     = 2'd1,   // req high, waiting for ack
        FETCH_RELEASE = 2'd2    // req dropped, waiting for ack low
    } fetch_state_t;

endpackage

`default_nettype wire

/* pixel_formatter.sv */
`default_nettype none
`timescale 1ns/1ps

module pixel_formatter (
    input  logic                  vtc_clk,
    input  logic                  arst_n_i,
    input  pipe_pkg::video_sync_t sync_i,
    input  pipe_pkg::pixel_t      pixel_i,
    input  pipe_pkg::out_mode_t   mode_i,
    input  pipe_pkg::pixel_t      threshold_i,
    output pipe_pkg::video_sync_t sync_o,
    output pipe_pkg::rgb_t        rgb_o
);
    import pipe_pkg::*;

    pixel_t level;
    rgb_t   rgb_next;

    always_comb begin
        if (mode_i == MODE_BINARY) begin
            level = (pixel_i >= threshold_i) ? '1 : '0;
        end else begin
            level = pixel_i;   // grey
        end
        if (sync_i.de) begin
            rgb_next.red   = level;
            rgb_next.green = level;
            rgb_next.blue  = level;
        end else begin
            rgb_next = '0;     // blank outside active video
        end
    end

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_o <= '0;
            rgb_o  <= '0;
        end else begin
            sync_o <= sync_i;
            rgb_o  <= rgb_next;
        end
    end

endmodule

`default_nettype wire

/* tb_display_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_display_pipe;
    import pipe_pkg::*;

    typedef struct packed {
        int   cycles;
        int   de_cycles;
        int   de_lines;
        int   hs_cycles;
        int   vs_cycles;
        int   requests;
        logic underrun;
    } frame_stats_t;

    localparam int frame_cycles   = h_total * v_total;
    localparam int frame_pixels   = h_active * v_active;
    localparam int timeout_cycles = 6 * frame_cycles + 4 * h_total;   // six windows plus margin

    logic        vtc_clk = 1'b0;
    logic        arst_n;
    logic        mem_req;
    word_addr_t  mem_addr;
    logic        mem_ack;
    mem_word_t   mem_data;
    out_mode_t   mode;
    pixel_t      threshold;
    video_sync_t video;
    rgb_t        pixel;
    logic        underrun;

    integer       seed = 32'h00d1_1e7a;
    mem_word_t    frame_mem [frame_words];
    rgb_t         cap [frame_pixels];       // pixels of the current window
    rgb_t         ref_pix [frame_pixels];
    frame_stats_t cur;
    frame_stats_t last;
    int           pix_idx;
    logic         vs_prev;
    logic         de_prev;
    logic         req_prev;
    logic         check_pix;
    logic         slow;                     // memory answers after 8 to 12 cycles
    int           wait_cnt;
    int           cycle_cnt = 0;
    int           err_cnt = 0;
    int           pass_cnt = 0;
    int           fail_cnt = 0;
    int           e;
    int           reset_errs;
    event         frame_end;

    display_pipe_top uut (
        .vtc_clk     (vtc_clk),
        .arst_n_i    (arst_n),
        .mem_req_o   (mem_req),
        .mem_addr_o  (mem_addr),
        .mem_ack_i   (mem_ack),
        .mem_data_i  (mem_data),
        .mode_i      (mode),
        .threshold_i (threshold),
        .video_o     (video),
        .pixel_o     (pixel),
        .underrun_o  (underrun)
    );

    always #4 vtc_clk = ~vtc_clk;

    function automatic rgb_t expected_rgb(input int idx);
        mem_word_t word;
        pixel_t    b;
        word = frame_mem[idx / 4];          // four pixels per word
        b = word[31 - 8 * (idx % 4) -: 8];  // msb first
        if (mode == MODE_BINARY) begin
            b = (b >= threshold) ? 8'hff : 8'h00;
        end
        return '{red: b, green: b, blue: b};
    endfunction

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input int idx);
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: pixel %0d is %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_sync_counts(input frame_stats_t got);
        frame_stats_t exp;
        exp = '{cycles: frame_cycles, de_cycles: frame_pixels, de_lines: v_active,
                hs_cycles: h_sync * v_total, vs_cycles: v_sync * h_total,
                requests: got.requests, underrun: got.underrun};
        if (got !== exp) begin
            err_cnt++;
            $write("mismatch at %0t: frame cyc/de/lines/hs/vs %0d/%0d/%0d/%0d/%0d",
                   $time, got.cycles, got.de_cycles, got.de_lines, got.hs_cycles,
                   got.vs_cycles);
            $display(", expected %0d/%0d/%0d/%0d/%0d", exp.cycles, exp.de_cycles,
                     exp.de_lines, exp.hs_cycles, exp.vs_cycles);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAILED with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // four-phase memory, one phase per response
    always @(posedge vtc_clk) begin
        if (mem_req != mem_ack) begin
            if (wait_cnt > 0) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                if (mem_req) begin
                    mem_data <= frame_mem[mem_addr];
                end
                mem_ack  <= mem_req;
                wait_cnt <= slow ? 8 + $unsigned($random(seed)) % 5
                                 : $unsigned($random(seed)) % 2;
            end
        end
    end

    // output monitor, a window runs from one vs rise to the next
    always @(negedge vtc_clk) begin
        if (arst_n) begin
            if (video.vs && !vs_prev) begin
                last = cur;
                cur = '0;
                pix_idx = 0;
                -> frame_end;
            end
            cur.cycles++;
            if (video.de) begin
                cur.de_cycles++;
                if (!de_prev) begin
                    cur.de_lines++;
                end
                if (pix_idx < frame_pixels) begin
                    cap[pix_idx] = pixel;
                    if (check_pix) begin
                        check_rgb(pixel, expected_rgb(pix_idx), pix_idx);
                    end
                end
                pix_idx++;
            end
            if (video.hs) begin
                cur.hs_cycles++;
            end
            if (video.vs) begin
                cur.vs_cycles++;
            end
            if (mem_req && !req_prev) begin
                cur.requests++;   // one rise per word fetch
            end
            if (underrun) begin
                cur.underrun = 1'b1;
            end
            vs_prev  = video.vs;
            de_prev  = video.de;
            req_prev = mem_req;
        end
    end

    always @(posedge vtc_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        arst_n    = 1'b0;
        mem_ack   = 1'b0;
        mem_data  = '0;
        mode      = MODE_GREY;
        threshold = '0;
        slow      = 1'b0;
        check_pix = 1'b1;
        wait_cnt  = 0;
        cur       = '0;
        last      = '0;
        pix_idx   = 0;
        vs_prev   = 1'b0;
        de_prev   = 1'b0;
        req_prev  = 1'b0;
        for (int i = 0; i < frame_words; i++) begin
            frame_mem[i] = $random(seed);
        end

        // nothing moves while reset is held
        repeat (8) begin
            @(negedge vtc_clk);
            check_flag(mem_req, 1'b0, "mem_req_o in reset");
            check_flag(underrun, 1'b0, "underrun_o in reset");
            check_flag(|video, 1'b0, "video_o in reset");
            check_rgb(pixel, '0, -1);
        end
        reset_errs = err_cnt;
        @(posedge vtc_clk);
        arst_n <= 1'b1;

        @(frame_end);
        e = err_cnt;
        @(frame_end);
        finish_test("grey frame", e);

        e = err_cnt;
        @(posedge vtc_clk);
        mode      <= MODE_BINARY;   // vs is high here
        threshold <= pixel_t'($random(seed));
        @(frame_end);
        finish_test("binary threshold", e);

        e = err_cnt - reset_errs;
        @(posedge vtc_clk);
        mode <= MODE_GREY;
        @(frame_end);
        check_sync_counts(last);
        ref_pix = cap;
        finish_test("raster timing and reset", e);

        e = err_cnt;
        @(frame_end);
        check_count(last.requests, frame_words, "requests per frame");
        for (int i = 0; i < frame_pixels; i++) begin
            check_rgb(cap[i], ref_pix[i], i);
        end
        finish_test("refetch from word 0", e);

        e = err_cnt;
        check_pix = 1'b0;
        @(posedge vtc_clk);
        slow <= 1'b1;
        @(frame_end);
        check_flag(last.underrun, 1'b1, "underrun_o with slow memory");
        check_flag(underrun, 1'b0, "underrun_o after flush");
        @(posedge vtc_clk);
        slow <= 1'b0;
        check_pix = 1'b1;
        @(frame_end);
        check_flag(last.underrun, 1'b0, "underrun_o with fast memory");
        finish_test("underrun", e);

        if (uut.u_ctrl.u_props.assert_fails != 0) begin
            $display("%0d assertion failures", uut.u_ctrl.u_props.assert_fails);
            err_cnt += uut.u_ctrl.u_props.assert_fails;
        end
        $display("%0d tests: %0d ok, %0d failed, %0d errors",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* video_timing_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module video_timing_gen (
    input  logic                  vtc_clk,
    input  logic                  arst_n_i,
    output pipe_pkg::video_sync_t sync_o,
    output logic                  flush_o
);
    import pipe_pkg::*;

    hcount_t     h_cnt_q;
    vcount_t     v_cnt_q;
    video_sync_t sync_next;
    logic        flush_next;
    logic        line_end;

    assign line_end = (h_cnt_q == hcount_t'(h_total - 1));

    // region decode from the current counter position
    always_comb begin
        sync_next.de = (h_cnt_q < hcount_t'(h_active)) && (v_cnt_q < vcount_t'(v_active));
        sync_next.hs = (h_cnt_q >= hcount_t'(h_active + h_fp)) &&
                       (h_cnt_q <  hcount_t'(h_active + h_fp + h_sync));
        sync_next.vs = (v_cnt_q >= vcount_t'(v_active + v_fp)) &&
                       (v_cnt_q <  vcount_t'(v_active + v_fp + v_sync));
        flush_next   = (v_cnt_q == vcount_t'(v_active + v_fp)) && (h_cnt_q == '0);
    end

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // start at vertical sync so the first frame is prefetched
            h_cnt_q <= '0;
            v_cnt_q <= vcount_t'(v_active + v_fp);
            sync_o  <= '0;
            flush_o <= 1'b0;
        end else begin
            if (line_end) begin
                h_cnt_q <= '0;
                if (v_cnt_q == vcount_t'(v_total - 1)) begin
                    v_cnt_q <= '0;
                end else begin
                    v_cnt_q <= v_cnt_q + vcount_t'(1);
                end
            end else begin
                h_cnt_q <= h_cnt_q + hcount_t'(1);
            end
            sync_o  <= sync_next;     // one cycle behind the counters
            flush_o <= flush_next;    // first cycle of vs
        end
    end

endmodule

`default_nettype wire

/* word_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

module word_fifo (
    input  logic                  vtc_clk,
    input  logic                  arst_n_i,
    input  logic                  clear_i,
    input  logic                  push_i,
    input  pipe_pkg::mem_word_t   push_data_i,
    input  logic                  pop_i,
    output pipe_pkg::mem_word_t   head_o,
    output pipe_pkg::fifo_level_t level_o
);
    import pipe_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);

    mem_word_t         mem_q [fifo_depth];
    logic [ptr_w-1:0]  wr_ptr_q;
    logic [ptr_w-1:0]  rd_ptr_q;
    logic              do_push;
    logic              do_pop;

    assign do_push = push_i && (level_o != fifo_level_t'(fifo_depth));
    assign do_pop  = pop_i && (level_o != '0);     // empty pop is ignored
    assign head_o  = mem_q[rd_ptr_q];              // show-ahead

    always_ff @(posedge vtc_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_o  <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_o  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // depth is a power of two
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level_o <= level_o + fifo_level_t'(1);
                2'b01:   level_o <= level_o - fifo_level_t'(1);
                default: level_o <= level_o;
            endcase
        end
    end

    always_ff @(posedge vtc_clk) begin
        if (do_push && !clear_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire
